// File: rtl/bdHostPkg.sv
/* Word types, tag encoding and host address map for the bridge core.
   Every RTL module that touches pipe words imports this package. */
`default_nettype none

package bdHostPkg;

  //--------------------------------------------------------------------
  // Word types
  //--------------------------------------------------------------------
  typedef logic [31:0] hostWord;   // One pipe-in or pipe-out word
  typedef logic [15:0] regData;    // Register and channel contents
  typedef logic [4:0]  regId;      // Register or channel index
  typedef logic [25:0] downWord;   // {code[5:0], payload[19:0]} to the chip
  typedef logic [33:0] upWord;     // Raw word from the chip

  // Command tag in bits 31:30 of a pipe-in word
  // A top byte of all ones wins over the tag and marks an emulated upstream half
  typedef enum logic [1:0] {
    tagDown = 2'b00,               // Downstream chip word
    tagReg  = 2'b10,               // Configuration register write
    tagChan = 2'b11                // Channel register write
  } wordTag;

  //--------------------------------------------------------------------
  // Host address map
  //--------------------------------------------------------------------
  localparam logic [7:0] addrPipeIn   = 8'h80;  // Command words in
  localparam logic [7:0] addrPipeOut  = 8'hA0;  // Upstream words out
  localparam logic [7:0] addrRegBase  = 8'h00;  // Register n read at base + n
  localparam logic [7:0] addrChanBase = 8'h40;  // Channel n read at base + n

  // Returned on a pipe-out read with nothing queued
  localparam hostWord pipeOutEmpty = 32'hFFFF_FFFF;

  // Register 31 is the no-operation slot, never stored
  localparam regId nopReg = 5'd31;

  // Top byte of an emulated upstream half
  localparam logic [7:0] emuMark = 8'hFF;

  //--------------------------------------------------------------------
  // Bus request
  //--------------------------------------------------------------------
  // Wishbone classic request as driven by the host master
  typedef struct packed {
    logic       cyc;   // Bus cycle in progress
    logic       stb;   // Strobe, held until ack
    logic       we;    // Write enable
    logic [7:0] adr;   // Word address
    hostWord    dat;   // Write data
  } wbReq;

endpackage

`default_nettype wire

// File: rtl/syncFifo.sv
/* Synchronous circular-buffer FIFO with first-word fall-through.
   Holds the downstream chip words and the split upstream pipe words. */
`timescale 1ns/1ns
`default_nettype none

module syncFifo #(
  parameter int Width = 32,  // Bits per entry
  parameter int Depth = 8    // Number of entries
) (
  input  logic                         okClk,
  input  logic                         reset,
  input  logic [Width-1:0]             din,
  input  logic                         push,
  output logic                         full,
  output logic [Width-1:0]             dout,
  input  logic                         pop,
  output logic                         empty,
  output logic [$clog2(Depth+1)-1:0]   freeCount
);

  localparam int PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountW = $clog2(Depth + 1);

  logic [Width-1:0]  mem [Depth];   // Storage, no reset needed
  logic [PtrW-1:0]   wrPtr;         // Next slot to write
  logic [PtrW-1:0]   rdPtr;         // Current head
  logic [CountW-1:0] count;         // Entries held
  logic              doPush;
  logic              doPop;

  // Wrap at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  assign full      = (count == CountW'(Depth));
  assign empty     = (count == '0);
  assign freeCount = CountW'(Depth) - count;
  assign dout      = mem[rdPtr];    // Head visible without a pop

  always_ff @(posedge okClk) begin
    if (doPush) mem[wrPtr] <= din;
  end

  always_ff @(posedge okClk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= nextPtr(wrPtr);
      if (doPop)  rdPtr <= nextPtr(rdPtr);
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  //--------------------------------------------------------------------
  // Checks on the producer and consumer
  //--------------------------------------------------------------------
  pushNotFull: assert property (@(posedge okClk) disable iff (reset) push |-> !full)
    else $error("syncFifo overflow");
  popNotEmpty: assert property (@(posedge okClk) disable iff (reset) pop |-> !empty)
    else $error("syncFifo underflow");

endmodule

`default_nettype wire

// File: rtl/wbHostPort.sv
/* Wishbone classic slave for the host bus.
   Steers writes to pipe-in and reads to pipe-out or register readback. */
`timescale 1ns/1ns
`default_nettype none

module wbHostPort
  import bdHostPkg::*;
(
  input  logic    okClk,
  input  logic    reset,
  input  wbReq    wbIn,
  output logic    wbAck,
  output hostWord wbDatOut,
  output hostWord pipeIn,
  output logic    pipeInValid,
  input  logic    pipeInReady,
  output regId    readIdx,
  output logic    readChan,
  input  regData  readData,
  input  hostWord popData,
  input  logic    popEmpty,
  output logic    pop
);

  logic req;        // New request, not yet acked
  logic isPipeIn;
  logic isPipeOut;
  logic isReg;
  logic isChan;
  logic ackNext;

  //--------------------------------------------------------------------
  // Address decode
  //--------------------------------------------------------------------
  // The master still holds stb during the ack cycle, so mask it there
  assign req = wbIn.cyc && wbIn.stb && !wbAck;

  assign isPipeIn  = (wbIn.adr == addrPipeIn);
  assign isPipeOut = (wbIn.adr == addrPipeOut);
  assign isReg     = (wbIn.adr[7:5] == addrRegBase[7:5]);   // 32-word window
  assign isChan    = (wbIn.adr[7:5] == addrChanBase[7:5]);

  // Offset into whichever window is addressed
  assign readIdx  = regId'(wbIn.adr - (isChan ? addrChanBase : addrRegBase));
  assign readChan = isChan;

  assign pipeIn      = wbIn.dat;
  assign pipeInValid = req && wbIn.we && isPipeIn;   // Held until ready
  assign pop         = req && !wbIn.we && isPipeOut && !popEmpty;

  // Pipe-in writes wait for the decoder, everything else acks next cycle
  assign ackNext = req && (!pipeInValid || pipeInReady);

  always_ff @(posedge okClk) begin
    if (reset) wbAck <= 1'b0;
    else       wbAck <= ackNext;
  end

  // Read data, captured with the ack
  always_ff @(posedge okClk) begin
    if (req && !wbIn.we) begin
      if (isPipeOut) begin
        wbDatOut <= popEmpty ? pipeOutEmpty : popData;   // Head that is popped
      end else if (isReg || isChan) begin
        wbDatOut <= {16'h0000, readData};
      end else begin
        wbDatOut <= '0;   // Unmapped read
      end
    end
  end

  //--------------------------------------------------------------------
  // Bus protocol check
  //--------------------------------------------------------------------
  ackOneCycle: assert property (@(posedge okClk) disable iff (reset) wbAck |=> !wbAck)
    else $error("wbHostPort ack held for two cycles");

endmodule

`default_nettype wire

// File: rtl/hostWordDecoder.sv
/* Sorts pipe-in command words by tag into register writes, channel writes,
   downstream chip words and emulated upstream words; serves register readback. */
`timescale 1ns/1ns
`default_nettype none

module hostWordDecoder
  import bdHostPkg::*;
(
  input  logic    okClk,
  input  logic    reset,
  input  hostWord pipeIn,
  input  logic    pipeInValid,
  output logic    pipeInReady,
  input  regId    readIdx,
  input  logic    readChan,
  output regData  readData,
  output downWord downOut,
  output logic    downPush,
  input  logic    downFull,
  output upWord   emuWord,
  output logic    emuValid,
  input  logic    emuReady
);

  localparam int NumRegs = int'(nopReg);   // Slots 0 to 30
  localparam int NumChan = 32;

  regData [NumRegs-1:0] regFile;    // Configuration registers
  regData [NumChan-1:0] chanFile;   // Channel registers
  logic                 halfPending;   // First emulated half held
  logic [23:0]          lowHalf;       // Bits 23:0 of the emulated word
  wordTag               tag;
  logic                 isEmu;
  logic                 accept;
  regId                 wrId;
  regData               wrData;

  //--------------------------------------------------------------------
  // Field extraction
  //--------------------------------------------------------------------
  assign tag    = wordTag'(pipeIn[31:30]);
  assign isEmu  = (pipeIn[31:24] == emuMark);   // Overrides the tag
  assign wrId   = pipeIn[28:24];
  assign wrData = pipeIn[15:0];
  assign accept = pipeInValid && pipeInReady;

  always_comb begin
    pipeInReady = 1'b1;                              // Register writes never stall
    if (isEmu) pipeInReady = !(halfPending && emuValid);  // Second half needs the slot
    else if (tag == tagDown) pipeInReady = !downFull;
  end

  // Downstream words go straight into the FIFO in the accept cycle
  assign downOut  = {pipeIn[29:24], pipeIn[19:0]};   // Code then payload
  assign downPush = accept && !isEmu && (tag == tagDown);

  //--------------------------------------------------------------------
  // Register and channel files
  //--------------------------------------------------------------------
  always_ff @(posedge okClk) begin
    if (reset) begin
      regFile  <= '0;
      chanFile <= '0;
    end else if (accept && !isEmu) begin
      case (tag)
        tagReg:  if (wrId != nopReg) regFile[wrId] <= wrData;   // Slot 31 dropped
        tagChan: chanFile[wrId] <= wrData;
        default: ;   // Downstream or unused tag
      endcase
    end
  end

  assign readData = readChan ? chanFile[readIdx]
                  : (readIdx == nopReg) ? '0 : regFile[readIdx];

  //--------------------------------------------------------------------
  // Emulated upstream reassembly
  //--------------------------------------------------------------------
  always_ff @(posedge okClk) begin
    if (reset) begin
      halfPending <= 1'b0;
      emuValid    <= 1'b0;
    end else begin
      if (emuValid && emuReady) emuValid <= 1'b0;   // Packer took it
      if (accept && isEmu) begin
        halfPending <= !halfPending;
        if (halfPending) emuValid <= 1'b1;          // Word complete
      end
    end
  end

  always_ff @(posedge okClk) begin
    if (accept && isEmu) begin
      if (!halfPending) lowHalf <= pipeIn[23:0];
      else              emuWord <= {pipeIn[9:0], lowHalf};   // High bits 33:24
    end
  end

  // A write aimed at the no-op slot leaves every register untouched
  nopNoStore: assert property (@(posedge okClk) disable iff (reset)
    (accept && !isEmu && tag == tagReg && wrId == nopReg) |=> $stable(regFile))
    else $error("hostWordDecoder stored a no-op register write");

endmodule

`default_nettype wire

// File: rtl/upstreamPacker.sv
/* Merges emulated and chip upstream words, emulated first, and pushes
   each as two pipe-out words into the upstream FIFO. */
`timescale 1ns/1ns
`default_nettype none

module upstreamPacker
  import bdHostPkg::*;
#(
  parameter int Depth = 8   // Depth of the upstream FIFO
) (
  input  logic                       okClk,
  input  logic                       reset,
  input  upWord                      emuWord,
  input  logic                       emuValid,
  output logic                       emuReady,
  input  upWord                      bdUp,
  input  logic                       bdUpValid,
  output logic                       bdUpReady,
  output hostWord                    pushWord,
  output logic                       push,
  input  logic [$clog2(Depth+1)-1:0] freeCount
);

  typedef enum logic {
    stLow,    // Idle, word 0 goes out on accept
    stHigh    // Word 1 still owed
  } packState;

  packState    state;
  logic [9:0]  highBits;   // Bits 33:24 of the accepted word
  logic        haveRoom;
  logic        takeEmu;
  logic        takeChip;
  upWord       srcWord;

  //--------------------------------------------------------------------
  // Arbitration
  //--------------------------------------------------------------------
  assign haveRoom  = (freeCount >= 2);   // Both halves must fit
  assign emuReady  = (state == stLow) && haveRoom;
  assign bdUpReady = (state == stLow) && haveRoom && !emuValid;   // Emulation wins
  assign takeEmu   = emuValid && emuReady;
  assign takeChip  = bdUpValid && bdUpReady;
  assign srcWord   = takeEmu ? emuWord : bdUp;

  always_comb begin
    push     = 1'b0;
    pushWord = {8'h00, srcWord[23:0]};               // Word 0
    if (state == stHigh) begin
      push     = 1'b1;
      pushWord = {8'h01, 14'h0000, highBits};        // Word 1
    end else if (takeEmu || takeChip) begin
      push = 1'b1;
    end
  end

  always_ff @(posedge okClk) begin
    if (reset) begin
      state <= stLow;
    end else begin
      case (state)
        stLow:   if (takeEmu || takeChip) state <= stHigh;
        stHigh:  state <= stLow;
        default: state <= stLow;
      endcase
    end
  end

  always_ff @(posedge okClk) begin
    if (takeEmu || takeChip) highBits <= srcWord[33:24];
  end

  // Room check at accept must cover the second half as well
  pushHasRoom: assert property (@(posedge okClk) disable iff (reset)
    push |-> (freeCount != '0))
    else $error("upstreamPacker pushed into a full FIFO");

endmodule

`default_nettype wire

// File: rtl/bdHostCore.sv
/* Host side of the chip bridge. Wishbone host bus on one side,
   valid/ready downstream and upstream chip ports on the other. */
`timescale 1ns/1ns
`default_nettype none

module bdHostCore
  import bdHostPkg::*;
#(
  parameter int DownDepth = 8,   // Downstream chip word queue
  parameter int UpDepth   = 8    // Upstream pipe word queue
) (
  input  logic    okClk,
  input  logic    reset,
  input  wbReq    wbIn,
  output logic    wbAck,
  output hostWord wbDatOut,
  output downWord bdDown,
  output logic    bdDownValid,
  input  logic    bdDownReady,
  input  upWord   bdUp,
  input  logic    bdUpValid,
  output logic    bdUpReady
);

  // Pipe-in and readback
  hostWord pipeIn;
  logic    pipeInValid, pipeInReady;
  regId    readIdx;
  logic    readChan;
  regData  readData;

  // Downstream queue
  downWord downOut;
  logic    downPush, downFull, downEmpty, downPop;

  // Upstream path
  upWord                       emuWord;
  logic                        emuValid, emuReady;
  hostWord                     upPushWord, upHead;
  logic                        upPush, upEmpty, upPop;
  logic [$clog2(UpDepth+1)-1:0] upFree;

  assign bdDownValid = !downEmpty;
  assign downPop     = bdDownValid && bdDownReady;   // Chip takes the head

  //--------------------------------------------------------------------
  // Host side
  //--------------------------------------------------------------------
  wbHostPort port_i (
    .okClk, .reset, .wbIn, .wbAck, .wbDatOut,
    .pipeIn, .pipeInValid, .pipeInReady,
    .readIdx, .readChan, .readData,
    .popData(upHead), .popEmpty(upEmpty), .pop(upPop)
  );

  hostWordDecoder decoder_i (
    .okClk, .reset, .pipeIn, .pipeInValid, .pipeInReady,
    .readIdx, .readChan, .readData,
    .downOut, .downPush, .downFull,
    .emuWord, .emuValid, .emuReady
  );

  //--------------------------------------------------------------------
  // Queues and upstream packing
  //--------------------------------------------------------------------
  syncFifo #(.Width($bits(downWord)), .Depth(DownDepth)) downFifo_i (
    .okClk, .reset, .din(downOut), .push(downPush), .full(downFull),
    .dout(bdDown), .pop(downPop), .empty(downEmpty), .freeCount()
  );

  upstreamPacker #(.Depth(UpDepth)) packer_i (
    .okClk, .reset, .emuWord, .emuValid, .emuReady,
    .bdUp, .bdUpValid, .bdUpReady,
    .pushWord(upPushWord), .push(upPush), .freeCount(upFree)
  );

  syncFifo #(.Width($bits(hostWord)), .Depth(UpDepth)) upFifo_i (
    .okClk, .reset, .din(upPushWord), .push(upPush), .full(),
    .dout(upHead), .pop(upPop), .empty(upEmpty), .freeCount(upFree)
  );

endmodule

`default_nettype wire

// File: test/tbHostTasks.svh
/* Host bus tasks, command word builders and random source for the bridge
   testbench. Included inside the testbench module and uses its signals. */
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

//----------------------------------------------------------------------
// Random source and bookkeeping
//----------------------------------------------------------------------
function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] nextRand();
  rngState = xorshift(rngState);   // Stimulus stream only
  return rngState;
endfunction

task automatic noteTimeout(input string what);
  timeouts++;
  $display("Timeout while waiting for %s", what);
endtask

//----------------------------------------------------------------------
// Command words, laid out by tag
//----------------------------------------------------------------------
function automatic hostWord regCmd(input regId id, input regData d);
  return {2'b10, 1'b0, id, 8'h00, d};
endfunction

function automatic hostWord chanCmd(input regId id, input regData d);
  return {2'b11, 1'b0, id, 8'h00, d};
endfunction

function automatic hostWord downCmd(input downWord w);
  return {2'b00, w[25:20], 4'h0, w[19:0]};   // Code in 29:24, payload in 19:0
endfunction

function automatic hostWord emuLowCmd(input upWord u);
  return {8'hFF, u[23:0]};
endfunction

function automatic hostWord emuHighCmd(input upWord u);
  return {8'hFF, 14'h0000, u[33:24]};
endfunction

//----------------------------------------------------------------------
// Wishbone master, starts and ends on a falling edge
//----------------------------------------------------------------------
task automatic busCycle(input logic we, input logic [7:0] adr, input hostWord dat,
                        output hostWord rdData);
  int waited;
  waited = 0;
  wbIn.cyc = 1'b1;
  wbIn.stb = 1'b1;
  wbIn.we  = we;
  wbIn.adr = adr;
  wbIn.dat = dat;
  busCount++;
  do begin
    @(negedge okClk);
    waited++;
  end while (!wbAck && waited < WaitLimit);
  if (!wbAck) noteTimeout("a bus ack");
  rdData   = wbDatOut;
  wbIn.cyc = 1'b0;   // Drop the request in the ack cycle
  wbIn.stb = 1'b0;
  wbIn.we  = 1'b0;
  @(negedge okClk);  // One idle cycle between requests
endtask

task automatic busWrite(input logic [7:0] adr, input hostWord dat);
  hostWord unused;
  busCycle(1'b1, adr, dat, unused);
endtask

task automatic busRead(input logic [7:0] adr, output hostWord dat);
  busCycle(1'b0, adr, '0, dat);
endtask

// Polls pipe-out until a word is queued
task automatic readPipeOut(output hostWord dat);
  int tries;
  tries = 0;
  do begin
    busRead(addrPipeOut, dat);
    tries++;
  end while (dat == pipeOutEmpty && tries < WaitLimit);
  if (dat == pipeOutEmpty) noteTimeout("pipe-out data");
endtask

`endif

// File: test/tbBdHostCore.sv
/* Testbench for the bridge core. Drives the host bus and both chip ports
   and checks readback, downstream order and upstream splitting. */
`timescale 1ns/1ns
`default_nettype none

module tbBdHostCore
  import bdHostPkg::*;
();

  localparam int ClkPeriod = 40;
  localparam int WaitLimit = 200;   // Cycles per wait
  localparam int NumDown   = 32;    // Enough to fill and stall the queue

  logic    okClk;
  logic    reset;
  wbReq    wbIn;
  logic    wbAck;
  hostWord wbDatOut;
  downWord bdDown;
  logic    bdDownValid, bdDownReady;
  upWord   bdUp;
  logic    bdUpValid, bdUpReady;

  int          checks = 0, errors = 0, timeouts = 0, busCount = 0, ackCount = 0;
  logic [31:0] rngState, readyRng;   // Stimulus and stall streams
  regData      regModel [32];
  regData      chanModel [32];
  downWord     downExpect [$];      // Words written, not yet seen on bdDown

  `include "tbHostTasks.svh"

  bdHostCore #(.DownDepth(8), .UpDepth(8)) dut_i (
    .okClk, .reset, .wbIn, .wbAck, .wbDatOut,
    .bdDown, .bdDownValid, .bdDownReady, .bdUp, .bdUpValid, .bdUpReady
  );

  initial begin
    okClk = 1'b0;
    forever #(ClkPeriod / 2) okClk = ~okClk;
  end

  task automatic checkValue(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic offerChipWord(input upWord w);
    int waited;
    waited = 0;
    bdUp      = w;
    bdUpValid = 1'b1;
    while (!bdUpReady && waited < WaitLimit) begin
      @(negedge okClk);
      waited++;
    end
    if (!bdUpReady) noteTimeout("bdUpReady");
    @(negedge okClk);   // Taken on the rising edge in between
    bdUpValid = 1'b0;
  endtask

  //--------------------------------------------------------------------
  // Chip side of the downstream port, random stalls
  //--------------------------------------------------------------------
  always @(negedge okClk) begin
    logic ready;
    if (reset) begin
      bdDownReady = 1'b0;
    end else begin
      readyRng    = xorshift(readyRng);
      ready       = readyRng[0] & readyRng[1];   // Ready about 1 cycle in 4
      bdDownReady = ready;
      if (bdDownValid && ready) begin            // Transfer on the next rising edge
        if (downExpect.size() == 0) begin
          errors++;
          $display("A downstream word appeared that was never written");
        end else begin
          checkValue("downOrder", {6'h00, downExpect.pop_front()}, {6'h00, bdDown});
        end
      end
    end
  end

  always @(negedge okClk) if (wbAck) ackCount++;

  // Bus and port protocol
  ackFollowsRequest: assert property (@(posedge okClk) disable iff (reset)
    wbAck |-> $past(wbIn.cyc && wbIn.stb))
    else begin
      errors++;
      $display("ackFollowsRequest: ack without a bus request");
    end
  ackSingleCycle: assert property (@(posedge okClk) disable iff (reset) wbAck |=> !wbAck)
    else begin
      errors++;
      $display("ackSingleCycle: ack held for two cycles");
    end
  downIdleAfterReset: assert property (@(posedge okClk) $past(reset) |-> !bdDownValid)
    else begin
      errors++;
      $display("downIdleAfterReset: bdDownValid high after reset");
    end
  downHeldOnStall: assert property (@(posedge okClk) disable iff (reset)
    (bdDownValid && !bdDownReady) |=> (bdDownValid && $stable(bdDown)))
    else begin
      errors++;
      $display("downHeldOnStall: bdDown changed while stalled");
    end

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------
  initial begin
    hostWord     rd;
    logic [31:0] r, r2;
    regId        id;
    downWord     dw;
    upWord       uw, uw2;
    int          waited;
    reset       = 1'b1;
    wbIn        = '0;
    bdDownReady = 1'b0;
    bdUp        = '0;
    bdUpValid   = 1'b0;
    rngState    = 32'hd7235723;
    readyRng    = 32'hd7235723;
    foreach (regModel[i]) regModel[i] = '0;
    foreach (chanModel[i]) chanModel[i] = '0;
    repeat (3) @(negedge okClk);   // Three rising edges in reset
    reset = 1'b0;

    busRead(addrPipeOut, rd);
    checkValue("pipeOutEmpty", pipeOutEmpty, rd);

    // Registers 0 to 30, then random ids, then the no-op slot
    for (int i = 0; i < 31; i++) begin
      r = nextRand();
      regModel[i] = r[15:0];
      busWrite(addrPipeIn, regCmd(regId'(i), r[15:0]));
    end
    for (int k = 0; k < 8; k++) begin
      r  = nextRand();
      id = r[20:16] % 5'd31;
      regModel[id] = r[15:0];
      busWrite(addrPipeIn, regCmd(id, r[15:0]));
    end
    busWrite(addrPipeIn, regCmd(5'd31, 16'hBEEF));

    for (int i = 0; i < 32; i++) begin
      r = nextRand();
      chanModel[i] = r[15:0];
      busWrite(addrPipeIn, chanCmd(regId'(i), r[15:0]));
    end
    for (int i = 0; i < 32; i++) begin
      busRead(addrRegBase + 8'(i), rd);
      checkValue("regReadback", {16'h0000, (i == 31) ? 16'h0000 : regModel[i]}, rd);
      busRead(addrChanBase + 8'(i), rd);
      checkValue("chanReadback", {16'h0000, chanModel[i]}, rd);
    end

    // Downstream words under random stalls
    for (int k = 0; k < NumDown; k++) begin
      r  = nextRand();
      dw = r[25:0];
      downExpect.push_back(dw);
      busWrite(addrPipeIn, downCmd(dw));
    end
    waited = 0;
    while (downExpect.size() != 0 && waited < WaitLimit) begin
      @(negedge okClk);
      waited++;
    end
    if (downExpect.size() != 0) noteTimeout("the downstream queue to drain");

    // Emulated upstream word from two halves
    r  = nextRand();
    r2 = nextRand();
    uw = {r2[9:0], r[23:0]};
    busWrite(addrPipeIn, emuLowCmd(uw));
    busWrite(addrPipeIn, emuHighCmd(uw));
    readPipeOut(rd);
    checkValue("emuWord0", {8'h00, uw[23:0]}, rd);
    readPipeOut(rd);
    checkValue("emuWord1", {8'h01, 14'h0000, uw[33:24]}, rd);

    // Two chip words, read back in arrival order
    r   = nextRand();
    r2  = nextRand();
    uw  = {r2[1:0], r};
    r   = nextRand();
    r2  = nextRand();
    uw2 = {r2[1:0], r};
    offerChipWord(uw);
    offerChipWord(uw2);
    readPipeOut(rd);
    checkValue("chipWord0", {8'h00, uw[23:0]}, rd);
    readPipeOut(rd);
    checkValue("chipWord1", {8'h01, 14'h0000, uw[33:24]}, rd);
    readPipeOut(rd);
    checkValue("chipWord0", {8'h00, uw2[23:0]}, rd);
    readPipeOut(rd);
    checkValue("chipWord1", {8'h01, 14'h0000, uw2[33:24]}, rd);

    busRead(addrPipeOut, rd);
    checkValue("pipeOutEmpty", pipeOutEmpty, rd);
    busRead(8'hC0, rd);   // Outside every window
    checkValue("unmappedRead", 32'h0, rd);
    checkValue("ackCount", 32'(busCount), 32'(ackCount));

    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bdHostCore.f
+incdir+test
rtl/bdHostPkg.sv
rtl/syncFifo.sv
rtl/wbHostPort.sv
rtl/hostWordDecoder.sv
rtl/upstreamPacker.sv
rtl/bdHostCore.sv
test/tbBdHostCore.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbBdHostCore \
  -f bdHostCore.f -Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1
